// File: include/exec_config.svh
/*
  Execution cluster configuration.
  Operand width, destination register number width and the
  iteration count of the radix-2 divider.
*/
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// operand and result width, 64 also works
`define XLEN 32

// destination register number width
`define REG_BITS 5

// one quotient bit per iteration cycle
`define DIV_CYCLES `XLEN

`endif

// File: src/execPkg.sv
/*
  Execution cluster types.
  Opcode encoding for issued operations and the divider FSM states.
*/
package execPkg;

  ////////////////////////////////////////
  // issue opcodes
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLT  = 4'h5,  // signed compare
    OP_SLL  = 4'h6,
    OP_SRL  = 4'h7,
    OP_MUL  = 4'h8,  // low half of product
    OP_DIVU = 4'h9,
    OP_REMU = 4'hA
  } execOpT;

  ////////////////////////////////////////
  // divider states
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,
    DIV_RUN  = 2'b01,  // shifting one bit per cycle
    DIV_DONE = 2'b10   // result ready to present
  } divStateT;

endpackage

// File: src/aluUnit.sv
/*
  Integer ALU.
  Decodes the issued opcode, computes add/sub/logic/compare/shift
  results in one cycle and registers result, rd and valid.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module aluUnit (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  issueValid,
  input  execPkg::execOpT       issueOp,
  input  logic [`XLEN-1:0]      issueSrcA,
  input  logic [`XLEN-1:0]      issueSrcB,
  input  logic [`REG_BITS-1:0]  issueRd,
  output logic                  aluValid,
  output logic [`REG_BITS-1:0]  aluRd,
  output logic [`XLEN-1:0]      aluData
);
  import execPkg::*;

  localparam int SHAMT_BITS = $clog2(`XLEN);

  logic [SHAMT_BITS-1:0] shamt;   // low bits of srcB only
  logic                  isAlu;   // opcode belongs here
  logic [`XLEN-1:0]      aluNext;

  assign shamt = issueSrcB[SHAMT_BITS-1:0];

  ////////////////////////////////////////
  // decode and compute
  ////////////////////////////////////////
  always_comb begin
    isAlu   = 1'b1;
    aluNext = '0;
    case (issueOp)
      OP_ADD:  aluNext = issueSrcA + issueSrcB;
      OP_SUB:  aluNext = issueSrcA - issueSrcB;
      OP_AND:  aluNext = issueSrcA & issueSrcB;
      OP_OR:   aluNext = issueSrcA | issueSrcB;
      OP_XOR:  aluNext = issueSrcA ^ issueSrcB;
      OP_SLT: begin
        // two's complement compare
        aluNext = {{(`XLEN-1){1'b0}}, ($signed(issueSrcA) < $signed(issueSrcB))};
      end
      OP_SLL:  aluNext = issueSrcA << shamt;
      OP_SRL:  aluNext = issueSrcA >> shamt;  // logical, zero fill
      default: isAlu = 1'b0;                  // mul/div handled elsewhere
    endcase
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluValid <= 1'b0;
    end else begin
      aluValid <= issueValid && isAlu;  // one cycle pulse
    end
  end

  // payload only moves on a taken ALU op
  always_ff @(posedge clk) begin
    if (issueValid && isAlu) begin
      aluRd   <= issueRd;
      aluData <= aluNext;
    end
  end

endmodule

// File: src/mulDivUnit.sv
/*
  Multiply/divide unit.
  Two-stage multiplier returning the low half of the product and a
  radix-2 restoring divider for DIVU/REMU, one quotient bit per cycle.
  Division by zero gives all ones or the dividend.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module mulDivUnit (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  issueValid,
  input  execPkg::execOpT       issueOp,
  input  logic [`XLEN-1:0]      issueSrcA,
  input  logic [`XLEN-1:0]      issueSrcB,
  input  logic [`REG_BITS-1:0]  issueRd,
  output logic                  mdValid,
  output logic [`REG_BITS-1:0]  mdRd,
  output logic [`XLEN-1:0]      mdData,
  output logic                  mulPending,
  output logic                  divBusy
);
  import execPkg::*;

  localparam int CNT_BITS = $clog2(`DIV_CYCLES + 1);

  // issue decode
  logic isMul;
  logic isDiv;
  logic divStart;

  // multiplier stage 1
  logic                 mulV1;
  logic [`XLEN-1:0]     mulA;
  logic [`XLEN-1:0]     mulB;
  logic [`REG_BITS-1:0] mulRd;
  logic [`XLEN-1:0]     mulLow;

  // divider
  divStateT             divState;
  logic [CNT_BITS-1:0]  divCnt;     // iterations left
  logic [2*`XLEN-1:0]   remQuo;     // remainder high, quotient low
  logic [`XLEN-1:0]     divisor;
  logic                 divIsRem;
  logic                 divZero;
  logic [`REG_BITS-1:0] divRd;
  logic [`XLEN:0]       partial;
  logic [`XLEN:0]       trial;
  logic [`XLEN-1:0]     divResult;

  assign isMul    = issueValid && (issueOp == OP_MUL);
  assign isDiv    = issueValid && ((issueOp == OP_DIVU) || (issueOp == OP_REMU));
  assign divStart = isDiv && (divState == DIV_IDLE);

  assign mulLow = mulA * mulB;  // truncated to XLEN

  ////////////////////////////////////////
  // divider datapath
  ////////////////////////////////////////
  assign partial = remQuo[2*`XLEN-1:`XLEN-1];  // rem shifted in with next bit
  assign trial   = partial - {1'b0, divisor};  // msb set means borrow

  always_comb begin
    if (divZero) begin
      divResult = divIsRem ? remQuo[`XLEN-1:0] : '1;  // low half still holds dividend
    end else begin
      divResult = divIsRem ? remQuo[2*`XLEN-1:`XLEN] : remQuo[`XLEN-1:0];
    end
  end

  ////////////////////////////////////////
  // control state
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mulV1    <= 1'b0;
      mdValid  <= 1'b0;
      divState <= DIV_IDLE;
      divCnt   <= '0;
    end else begin
      mulV1   <= isMul;
      mdValid <= mulV1 || (divState == DIV_DONE);  // never both, stall blocks issue
      case (divState)
        DIV_IDLE: begin
          if (divStart) begin
            divState <= DIV_RUN;
            divCnt   <= CNT_BITS'(`DIV_CYCLES);
          end
        end
        DIV_RUN: begin
          divCnt <= divCnt - 1'b1;
          if (divCnt == CNT_BITS'(1)) begin
            divState <= DIV_DONE;  // last bit this edge
          end
        end
        DIV_DONE: divState <= DIV_IDLE;  // result leaves with mdValid
        default:  divState <= DIV_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (isMul) begin
      mulA  <= issueSrcA;
      mulB  <= issueSrcB;
      mulRd <= issueRd;
    end

    if (divStart) begin
      remQuo   <= {{`XLEN{1'b0}}, issueSrcA};
      divisor  <= issueSrcB;
      divIsRem <= (issueOp == OP_REMU);
      divZero  <= (issueSrcB == '0);   // flagged once at start
      divRd    <= issueRd;
    end else if ((divState == DIV_RUN) && !divZero) begin
      if (trial[`XLEN]) begin
        remQuo <= {remQuo[2*`XLEN-2:0], 1'b0};  // restore, quotient bit 0
      end else begin
        remQuo <= {trial[`XLEN-1:0], remQuo[`XLEN-2:0], 1'b1};
      end
    end

    // shared result register, stage 2 of the multiplier
    if (mulV1) begin
      mdRd   <= mulRd;
      mdData <= mulLow;
    end else if (divState == DIV_DONE) begin
      mdRd   <= divRd;
      mdData <= divResult;
    end
  end

  assign mulPending = mulV1;
  assign divBusy    = (divState != DIV_IDLE);  // drops as mdValid rises

endmodule

// File: src/writebackCtrl.sv
/*
  Writeback controller.
  Picks the valid result from the ALU or the multiply/divide unit,
  commits it with x0 forced to zero, holds off issue while the
  multiplier or divider is busy and counts retired operations.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module writebackCtrl (
  input  logic                  clk,
  input  logic                  rstN,
  // integer ALU
  input  logic                  aluValid,
  input  logic [`REG_BITS-1:0]  aluRd,
  input  logic [`XLEN-1:0]      aluData,
  // multiply/divide
  input  logic                  mdValid,
  input  logic [`REG_BITS-1:0]  mdRd,
  input  logic [`XLEN-1:0]      mdData,
  input  logic                  mulPending,
  input  logic                  divBusy,
  // commit
  output logic                  resultValid,
  output logic [`REG_BITS-1:0]  resultRd,
  output logic [`XLEN-1:0]      resultData,
  output logic                  stall,
  output logic [31:0]           retireCount
);

  logic                 selValid;
  logic [`REG_BITS-1:0] selRd;
  logic [`XLEN-1:0]     selData;
  logic [`XLEN-1:0]     commitData;

  ////////////////////////////////////////
  // source select
  ////////////////////////////////////////
  // at most one source per cycle in legal use
  // md side wins a tie since it is always the older op
  assign selValid = aluValid | mdValid;

  always_comb begin
    if (mdValid) begin
      selRd   = mdRd;
      selData = mdData;
    end else begin
      selRd   = aluRd;
      selData = aluData;
    end
  end

  // x0 is hard-wired
  assign commitData = (selRd == '0) ? '0 : selData;

  ////////////////////////////////////////
  // issue hold-off
  ////////////////////////////////////////
  assign stall = mulPending | divBusy;

  ////////////////////////////////////////
  // commit stage
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      retireCount <= '0;
    end else begin
      resultValid <= selValid;  // pulse, no back-pressure
      if (selValid) begin
        retireCount <= retireCount + 32'd1;
      end
    end
  end

  // commit payload held between pulses
  always_ff @(posedge clk) begin
    if (selValid) begin
      resultRd   <= selRd;
      resultData <= commitData;
    end
  end

endmodule

// File: src/execCluster.sv
/*
  Execution cluster top.
  Integer ALU and multiply/divide unit side by side, both watching
  every issue strobe; the writeback controller joins their results
  in issue order and drives the issue stall.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module execCluster (
  input  logic                  clk,
  input  logic                  rstN,
  // issue
  input  logic                  issueValid,
  input  execPkg::execOpT       issueOp,
  input  logic [`XLEN-1:0]      issueSrcA,
  input  logic [`XLEN-1:0]      issueSrcB,
  input  logic [`REG_BITS-1:0]  issueRd,
  // result
  output logic                  resultValid,
  output logic [`REG_BITS-1:0]  resultRd,
  output logic [`XLEN-1:0]      resultData,
  output logic                  stall,
  output logic [31:0]           retireCount
);

  logic                 issueOk;     // issue strobe past the stall
  logic                 aluValid;
  logic [`REG_BITS-1:0] aluRd;
  logic [`XLEN-1:0]     aluData;
  logic                 mdValid;
  logic [`REG_BITS-1:0] mdRd;
  logic [`XLEN-1:0]     mdData;
  logic                 mulPending;
  logic                 divBusy;

  assign issueOk = issueValid & ~stall;  // strobes under stall are dropped

  aluUnit alu (
    .clk, .rstN,
    .issueValid(issueOk), .issueOp, .issueSrcA, .issueSrcB, .issueRd,
    .aluValid, .aluRd, .aluData
  );  // add/sub/logic/slt/shift

  mulDivUnit mdu (
    .clk, .rstN,
    .issueValid(issueOk), .issueOp, .issueSrcA, .issueSrcB, .issueRd,
    .mdValid, .mdRd, .mdData,
    .mulPending, .divBusy
  );  // mul, divu, remu

  writebackCtrl wbc (
    .clk, .rstN,
    .aluValid, .aluRd, .aluData,
    .mdValid, .mdRd, .mdData,
    .mulPending, .divBusy,
    .resultValid, .resultRd, .resultData,
    .stall, .retireCount
  );  // in-order commit and hold-off

endmodule

// File: bench/execCluster_checker.sv
/*
  Execution cluster port checker.
  Concurrent assertions on reset values, issue under stall,
  x0 results and the longest stall window.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module execCluster_checker (
  input logic                 clk,
  input logic                 rstN,
  input logic                 issueValid,
  input logic                 stall,
  input logic                 resultValid,
  input logic [`REG_BITS-1:0] resultRd,
  input logic [`XLEN-1:0]     resultData
);

  int failCount = 0;  // assertion failures so far

  // outputs quiet while reset is held
  resetQuiet: assert property (@(posedge clk) !rstN |-> (!stall && !resultValid))
    else begin
      failCount++;
      $error("stall or resultValid high during reset");
    end

  // driver must respect the hold-off
  noIssueUnderStall: assert property (@(posedge clk) disable iff (!rstN)
    stall |-> !issueValid)
    else begin
      failCount++;
      $error("issueValid raised while stall high");
    end

  // x0 always reads zero
  zeroRegZero: assert property (@(posedge clk) disable iff (!rstN)
    (resultValid && (resultRd == '0)) |-> (resultData == '0))
    else begin
      failCount++;
      $error("nonzero data committed to x0");
    end

  // longest hold-off is a full divide
  stallBounded: assert property (@(posedge clk) disable iff (!rstN)
    $rose(stall) |-> ##[1:`DIV_CYCLES + 2] !stall)
    else begin
      failCount++;
      $error("stall held longer than a divide");
    end

endmodule

// File: bench/execCluster_tb.sv
/*
  Execution cluster testbench.
  Applies a directed table and a seeded random mix, checks each
  committed result, its latency, the stall hold-off after every
  issue and the final retire count.
*/
`timescale 1ns/10ps
`include "exec_config.svh"

module execCluster_tb;
  import execPkg::*;

  localparam int RANDOM_ROWS = 40;

  logic                 clk;
  logic                 rstN;
  logic                 issueValid;
  execOpT               issueOp;
  logic [`XLEN-1:0]     issueSrcA;
  logic [`XLEN-1:0]     issueSrcB;
  logic [`REG_BITS-1:0] issueRd;
  logic                 resultValid;
  logic [`REG_BITS-1:0] resultRd;
  logic [`XLEN-1:0]     resultData;
  logic                 stall;
  logic [31:0]          retireCount;

  // stimulus table, one entry per row
  execOpT               tabOp[$];
  logic [`XLEN-1:0]     tabA[$];
  logic [`XLEN-1:0]     tabB[$];
  logic [`REG_BITS-1:0] tabRd[$];
  logic [`XLEN-1:0]     tabExp[$];

  // outstanding results, oldest first
  execOpT               expOp[$];
  logic [`REG_BITS-1:0] expRd[$];
  logic [`XLEN-1:0]     expData[$];
  int                   issuedAt[$];   // edge count before the issue edge

  integer seed;
  int     cycleCount = 0;
  int     cycleLimit;
  int     issueCount = 0;

  execCluster execCluster_inst (
    .clk, .rstN,
    .issueValid, .issueOp, .issueSrcA, .issueSrcB, .issueRd,
    .resultValid, .resultRd, .resultData, .stall, .retireCount
  );

  bind execCluster execCluster_checker portChecker (
    .clk(clk), .rstN(rstN), .issueValid(issueValid), .stall(stall),
    .resultValid(resultValid), .resultRd(resultRd), .resultData(resultData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////
  function automatic logic [`XLEN-1:0] expectedResult(execOpT op, logic [`XLEN-1:0] a,
                                                       logic [`XLEN-1:0] b,
                                                       logic [`REG_BITS-1:0] rd);
    logic [2*`XLEN-1:0] product;
    int unsigned        amount;
    logic [`XLEN-1:0]   r;
    product = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    amount  = b % `XLEN;  // shift amount wraps at XLEN
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLT:  r = (a[`XLEN-1] != b[`XLEN-1]) ? `XLEN'(a[`XLEN-1]) : `XLEN'(a < b);
      OP_SLL:  r = a << amount;
      OP_SRL:  r = a >> amount;
      OP_MUL:  r = product[`XLEN-1:0];
      OP_DIVU: r = (b == '0) ? '1 : a / b;
      OP_REMU: r = (b == '0) ? a : a % b;
      default: r = '0;
    endcase
    if (rd == '0) r = '0;  // x0 hard-wired
    return r;
  endfunction

  function automatic int expectedLatency(execOpT op);
    if (op == OP_MUL) return 3;
    if (op == OP_DIVU || op == OP_REMU) return `DIV_CYCLES + 3;
    return 2;  // any ALU op
  endfunction

  // cycles of issue hold-off right after an op
  function automatic int stallLength(execOpT op);
    if (op == OP_MUL) return 1;
    if (op == OP_DIVU || op == OP_REMU) return `DIV_CYCLES + 1;  // until mdValid
    return 0;
  endfunction

  task automatic reportFailure(string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic addRow(execOpT op, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
                        logic [`REG_BITS-1:0] rd, logic [`XLEN-1:0] want);
    tabOp.push_back(op);
    tabA.push_back(a);
    tabB.push_back(b);
    tabRd.push_back(rd);
    tabExp.push_back(want);
  endtask

  // called at posedge + 1 ns, returns at the same phase
  task automatic issueRow(int idx);
    int holdCycles;
    holdCycles = 0;
    issueValid = 1'b1;
    issueOp    = tabOp[idx];
    issueSrcA  = tabA[idx];
    issueSrcB  = tabB[idx];
    issueRd    = tabRd[idx];
    expOp.push_back(tabOp[idx]);
    expRd.push_back(tabRd[idx]);
    expData.push_back(tabExp[idx]);
    issuedAt.push_back(cycleCount);
    issueCount++;
    @(posedge clk);
    #1;
    issueValid = 1'b0;
    // hold-off raised by this op
    while (stall) begin
      holdCycles++;
      @(posedge clk);
      #1;
    end
    checkValue("stall length", holdCycles, stallLength(tabOp[idx]));
  endtask

  ////////////////////////////////////////
  // result monitor and watchdog
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (rstN && resultValid) begin
      if (expRd.size() == 0) begin
        reportFailure("result committed with no issue outstanding");
      end else begin
        checkValue("resultRd", resultRd, expRd[0]);
        checkValue("resultData", resultData, expData[0]);
        checkValue("latency", cycleCount - issuedAt[0], expectedLatency(expOp[0]));
        void'(expOp.pop_front());
        void'(expRd.pop_front());
        void'(expData.pop_front());
        void'(issuedAt.pop_front());
      end
    end
  end

  // bound port checker
  always @(negedge clk) begin
    if (execCluster_inst.portChecker.failCount != 0) begin
      reportFailure("an assertion of the port checker failed");
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      reportFailure($sformatf("run hung, not finished after %0d cycles", cycleCount));
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    execOpT               op;
    logic [`XLEN-1:0]     a;
    logic [`XLEN-1:0]     b;
    logic [`REG_BITS-1:0] rd;
    rstN       = 1'b1;
    issueValid = 1'b0;
    issueOp    = OP_ADD;
    issueSrcA  = '0;
    issueSrcB  = '0;
    issueRd    = '0;
    seed       = 32'h17b55632;

    addRow(OP_ADD,  32'h00000005, 32'h00000007, 5'd1,  32'h0000000C);
    addRow(OP_ADD,  32'hFFFFFFFF, 32'h00000001, 5'd2,  32'h00000000);  // wraps
    addRow(OP_SUB,  32'h0000000A, 32'h00000003, 5'd3,  32'h00000007);
    addRow(OP_SUB,  32'h00000003, 32'h0000000A, 5'd4,  32'hFFFFFFF9);
    addRow(OP_AND,  32'hF0F0F0F0, 32'hFF00FF00, 5'd5,  32'hF000F000);
    addRow(OP_OR,   32'hF0F0F0F0, 32'h0F0F0000, 5'd6,  32'hFFFFF0F0);
    addRow(OP_XOR,  32'hAAAA5555, 32'hFFFF0000, 5'd7,  32'h55555555);
    addRow(OP_SLT,  32'hFFFFFFFB, 32'h00000003, 5'd8,  32'h00000001);  // -5 < 3
    addRow(OP_SLT,  32'h00000003, 32'hFFFFFFFB, 5'd9,  32'h00000000);
    addRow(OP_SLT,  32'hFFFFFFF8, 32'hFFFFFFFE, 5'd10, 32'h00000001);  // -8 < -2
    addRow(OP_SLL,  32'h00000001, 32'h00000014, 5'd11, 32'h00100000);
    addRow(OP_SLL,  32'h12345678, 32'h00000024, 5'd12, 32'h23456780);  // 36 wraps to 4
    addRow(OP_SRL,  32'h80000000, 32'h0000001F, 5'd13, 32'h00000001);
    addRow(OP_SRL,  32'hF0000000, 32'h00000010, 5'd14, 32'h0000F000);
    addRow(OP_MUL,  32'h00000007, 32'h00000006, 5'd15, 32'h0000002A);
    addRow(OP_ADD,  32'h00000001, 32'h00000001, 5'd16, 32'h00000002);  // right behind mul
    addRow(OP_MUL,  32'hFFFFFFFF, 32'hFFFFFFFF, 5'd17, 32'h00000001);
    addRow(OP_DIVU, 32'h00000064, 32'h00000007, 5'd18, 32'h0000000E);
    addRow(OP_REMU, 32'h00000064, 32'h00000007, 5'd19, 32'h00000002);
    addRow(OP_DIVU, 32'hFFFFFFFF, 32'h00000001, 5'd20, 32'hFFFFFFFF);
    addRow(OP_DIVU, 32'h00000005, 32'h00000000, 5'd21, 32'hFFFFFFFF);  // divide by zero
    addRow(OP_REMU, 32'h000004D2, 32'h00000000, 5'd22, 32'h000004D2);
    addRow(OP_REMU, 32'h80000000, 32'h00000003, 5'd23, 32'h00000002);
    addRow(OP_ADD,  32'h00000005, 32'h00000005, 5'd0,  32'h00000000);  // x0 rows
    addRow(OP_MUL,  32'h00000003, 32'h00000003, 5'd0,  32'h00000000);
    addRow(OP_DIVU, 32'h00000064, 32'h00000005, 5'd0,  32'h00000000);
    addRow(OP_REMU, 32'h000004D2, 32'h00000000, 5'd0,  32'h00000000);

    for (int i = 0; i < RANDOM_ROWS; i++) begin
      op = execOpT'($unsigned($random(seed)) % 11);
      a  = $random(seed);
      b  = $random(seed);
      if ((op == OP_DIVU || op == OP_REMU) && (($random(seed) & 3) == 0)) b = '0;
      rd = $random(seed);
      addRow(op, a, b, rd, expectedResult(op, a, b, rd));
    end
    cycleLimit = tabOp.size() * (`DIV_CYCLES + 4) + 200;

    #1 rstN = 1'b0;
    repeat (16) @(posedge clk);
    #1 rstN = 1'b1;
    checkValue("stall", stall, 0);
    checkValue("resultValid", resultValid, 0);
    checkValue("retireCount", retireCount, 0);

    for (int i = 0; i < tabOp.size(); i++) issueRow(i);

    while (expRd.size() != 0) begin  // drain, watchdog bounds it
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    checkValue("retireCount", retireCount, issueCount);
    if (execCluster_inst.portChecker.failCount != 0) begin
      reportFailure("an assertion of the port checker failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: execCluster.f
+incdir+include
src/execPkg.sv
src/aluUnit.sv
src/mulDivUnit.sv
src/writebackCtrl.sv
src/execCluster.sv
bench/execCluster_checker.sv
bench/execCluster_tb.sv
